//--- design/axi_bridge_top.sv
`timescale 1ns/1ps

module axi_bridge_top import cache_port_pkg::*, axi_pkg::*; (
    input  logic      aclk,
    input  logic      reset,

    // icache refill
    input  logic      icache_rd_req,
    input  addr_t     icache_rd_addr,
    output logic      icache_rd_rdy,
    output logic      icache_ret_valid,
    output line_t     icache_ret_data,

    // dcache refill and write-back
    input  logic      dcache_rd_req,
    input  addr_t     dcache_rd_addr,
    output logic      dcache_rd_rdy,
    output logic      dcache_ret_valid,
    output line_t     dcache_ret_data,
    input  logic      dcache_wr_req,
    input  addr_t     dcache_wr_addr,
    input  line_t     dcache_wr_data,
    output logic      dcache_wr_rdy,
    output logic      dcache_wr_valid,

    // uncached word access
    input  logic      udcache_rd_req,
    input  addr_t     udcache_rd_addr,
    output logic      udcache_rd_rdy,
    output logic      udcache_ret_valid,
    output word_t     udcache_ret_data,
    input  logic      udcache_wr_req,
    input  addr_t     udcache_wr_addr,
    input  strb_t     udcache_wr_strb,
    input  word_t     udcache_wr_data,
    output logic      udcache_wr_rdy,
    output logic      udcache_wr_valid,

    // AXI3 master with fixed size and burst fields left to the slave
    output axi_id_t   arid,
    output addr_t     araddr,
    output axi_len_t  arlen,
    output logic      arvalid,
    input  logic      arready,
    input  axi_id_t   rid,
    input  word_t     rdata,
    input  axi_resp_t rresp,
    input  logic      rlast,
    input  logic      rvalid,
    output logic      rready,
    output axi_id_t   awid,
    output addr_t     awaddr,
    output axi_len_t  awlen,
    output logic      awvalid,
    input  logic      awready,
    output word_t     wdata,
    output strb_t     wstrb,
    output logic      wlast,
    output logic      wvalid,
    input  logic      wready,
    input  axi_id_t   bid,
    input  axi_resp_t bresp,
    input  logic      bvalid,
    output logic      bready
);

    // arbiter to read engine
    rd_port_if rd_port ();

    // three read clients onto one read port
    read_arbiter u_read_arbiter (
        .port (rd_port),
        .*
    );

    // AR and R channels
    axi_read_engine u_axi_read_engine (
        .port (rd_port),
        .*
    );

    // AW, W and B channels with their own two-client arbiter
    axi_write_engine u_axi_write_engine (
        .*
    );

endmodule

//--- design/axi_pkg.sv
package axi_pkg;

    // transaction id per client
    typedef logic [3:0] axi_id_t;

    // burst length field holding beats minus one
    typedef logic [3:0] axi_len_t;

    // rresp / bresp code
    typedef logic [1:0] axi_resp_t;

    // four-beat INCR burst for a cache line
    localparam axi_len_t AXI_LEN_LINE = 4'd3;
    // single beat for uncached access
    localparam axi_len_t AXI_LEN_WORD = 4'd0;

    // normal access success
    localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

    // ids shared by read and write channels
    localparam axi_id_t ID_ICACHE   = 4'd0;
    localparam axi_id_t ID_DCACHE   = 4'd1;
    localparam axi_id_t ID_UNCACHED = 4'd2;

endpackage

//--- design/axi_read_engine.sv
`timescale 1ns/1ps

module axi_read_engine import cache_port_pkg::*, axi_pkg::*; (
    input  logic      aclk,
    input  logic      reset,
    rd_port_if.engine port,

    output axi_id_t   arid,
    output addr_t     araddr,
    output axi_len_t  arlen,
    output logic      arvalid,
    input  logic      arready,

    input  axi_id_t   rid,
    input  word_t     rdata,
    input  axi_resp_t rresp,
    input  logic      rlast,
    input  logic      rvalid,
    output logic      rready
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA
    } state_t;

    state_t   state_q;
    beat_t    beat_q;
    logic     ret_valid_q;

    // latched AR payload
    axi_id_t  id_q;
    addr_t    addr_q;
    axi_len_t len_q;
    // assembled line
    line_t    line_q;

    axi_id_t  req_id;
    addr_t    req_addr;
    axi_len_t req_len;
    logic     accept;
    logic     beat_take;

    // id, length and alignment per client
    always_comb begin
        case (port.client)
            CLIENT_ICACHE: begin
                req_id   = ID_ICACHE;
                req_len  = AXI_LEN_LINE;
                req_addr = line_align(port.addr);
            end
            CLIENT_DCACHE: begin
                req_id   = ID_DCACHE;
                req_len  = AXI_LEN_LINE;
                req_addr = line_align(port.addr);
            end
            default: begin
                req_id   = ID_UNCACHED;
                req_len  = AXI_LEN_WORD;
                req_addr = port.addr;
            end
        endcase
    end

    assign port.rdy = (state_q == S_IDLE);
    assign accept   = port.req && port.rdy;
    // only beats of our own burst count
    assign beat_take = rvalid && rready && (rid == id_q);

    always_ff @(posedge aclk) begin
        if (accept) begin
            id_q   <= req_id;
            addr_q <= req_addr;
            len_q  <= req_len;
        end
    end

    // beats fill the line in address order
    // an error beat loads zero into its word
    always_ff @(posedge aclk) begin
        if (beat_take) begin
            line_q[beat_q*$bits(word_t) +: $bits(word_t)] <=
                (rresp == AXI_RESP_OKAY) ? rdata : '0;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            state_q     <= S_IDLE;
            beat_q      <= '0;
            ret_valid_q <= 1'b0;
        end else begin
            // completion is a single-cycle pulse
            ret_valid_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (accept) begin
                        state_q <= S_ADDR;
                        beat_q  <= '0;
                    end
                end
                S_ADDR: begin
                    if (arready) begin
                        state_q <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (beat_take) begin
                        beat_q <= beat_q + 1'b1;
                        if (rlast) begin
                            state_q     <= S_IDLE;
                            ret_valid_q <= 1'b1;
                        end
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    assign arid    = id_q;
    assign araddr  = addr_q;
    assign arlen   = len_q;
    assign arvalid = (state_q == S_ADDR);
    assign rready  = (state_q == S_DATA);

    assign port.ret_valid = ret_valid_q;
    assign port.ret_data  = line_q;

endmodule

//--- design/axi_write_engine.sv
`timescale 1ns/1ps

module axi_write_engine import cache_port_pkg::*, axi_pkg::*; (
    input  logic      aclk,
    input  logic      reset,

    input  logic      dcache_wr_req,
    input  addr_t     dcache_wr_addr,
    input  line_t     dcache_wr_data,
    output logic      dcache_wr_rdy,
    output logic      dcache_wr_valid,

    input  logic      udcache_wr_req,
    input  addr_t     udcache_wr_addr,
    input  strb_t     udcache_wr_strb,
    input  word_t     udcache_wr_data,
    output logic      udcache_wr_rdy,
    output logic      udcache_wr_valid,

    output axi_id_t   awid,
    output addr_t     awaddr,
    output axi_len_t  awlen,
    output logic      awvalid,
    input  logic      awready,

    output word_t     wdata,
    output strb_t     wstrb,
    output logic      wlast,
    output logic      wvalid,
    input  logic      wready,

    input  axi_id_t   bid,
    input  axi_resp_t bresp,
    input  logic      bvalid,
    output logic      bready
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_RESP
    } state_t;

    state_t   state_q;
    client_t  client_q;
    beat_t    beat_q;
    logic     done_q;

    // latched write request
    axi_id_t  id_q;
    addr_t    addr_q;
    axi_len_t len_q;
    line_t    data_q;
    strb_t    strb_q;

    logic     take_d;
    logic     take_u;
    logic     b_take;

    // dcache wins and uncached goes only when dcache is quiet
    assign dcache_wr_rdy  = (state_q == S_IDLE);
    assign udcache_wr_rdy = (state_q == S_IDLE) && !dcache_wr_req;

    assign take_d = dcache_wr_req && dcache_wr_rdy;
    assign take_u = udcache_wr_req && udcache_wr_rdy;
    assign b_take = bvalid && bready && (bid == id_q);

    always_ff @(posedge aclk) begin
        if (take_d) begin
            id_q   <= ID_DCACHE;
            addr_q <= line_align(dcache_wr_addr);
            len_q  <= AXI_LEN_LINE;
            data_q <= dcache_wr_data;
            // write-back always covers whole words
            strb_q <= '1;
        end else if (take_u) begin
            id_q   <= ID_UNCACHED;
            addr_q <= udcache_wr_addr;
            len_q  <= AXI_LEN_WORD;
            // single word goes out as beat 0
            data_q <= {{($bits(line_t)-$bits(word_t)){1'b0}}, udcache_wr_data};
            strb_q <= udcache_wr_strb;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            state_q  <= S_IDLE;
            client_q <= CLIENT_DCACHE;
            beat_q   <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (take_d) begin
                        state_q  <= S_ADDR;
                        client_q <= CLIENT_DCACHE;
                    end else if (take_u) begin
                        state_q  <= S_ADDR;
                        client_q <= CLIENT_UNCACHED;
                    end
                end
                S_ADDR: begin
                    // W starts only once AW is through
                    if (awready) begin
                        state_q <= S_DATA;
                        beat_q  <= '0;
                    end
                end
                S_DATA: begin
                    if (wready) begin
                        if (wlast) begin
                            state_q <= S_RESP;
                        end else begin
                            beat_q <= beat_q + 1'b1;
                        end
                    end
                end
                S_RESP: begin
                    if (b_take) begin
                        if (bresp == AXI_RESP_OKAY) begin
                            state_q <= S_IDLE;
                            done_q  <= 1'b1;
                        end else begin
                            // an error response replays the whole burst
                            state_q <= S_ADDR;
                        end
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    assign awid    = id_q;
    assign awaddr  = addr_q;
    assign awlen   = len_q;
    assign awvalid = (state_q == S_ADDR);

    // beat select from the latched line
    assign wdata  = data_q[beat_q*$bits(word_t) +: $bits(word_t)];
    assign wstrb  = strb_q;
    assign wvalid = (state_q == S_DATA);
    // last beat index equals the length code
    assign wlast  = wvalid && (beat_q == len_q[$bits(beat_t)-1:0]);

    assign bready = (state_q == S_RESP);

    // completion pulse back to whoever was accepted
    assign dcache_wr_valid  = done_q && (client_q == CLIENT_DCACHE);
    assign udcache_wr_valid = done_q && (client_q == CLIENT_UNCACHED);

endmodule

//--- design/cache_port_pkg.sv
package cache_port_pkg;

    // byte address, data word, byte strobe
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    // words per cache line, byte offset bits within a line
    localparam int LINE_WORDS       = 4;
    localparam int LINE_OFFSET_BITS = 4;

    // word 0 (lowest address) in the low 32 bits
    typedef logic [LINE_WORDS*$bits(word_t)-1:0] line_t;

    // beat index inside a line burst
    typedef logic [$clog2(LINE_WORDS)-1:0] beat_t;

    // requesters seen by the bridge
    typedef enum logic [1:0] {
        CLIENT_ICACHE   = 2'd0,
        CLIENT_DCACHE   = 2'd1,
        CLIENT_UNCACHED = 2'd2
    } client_t;

    // line base address with the offset bits cleared
    function automatic addr_t line_align(input addr_t addr);
        return {addr[$bits(addr_t)-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
    endfunction

endpackage

//--- design/rd_port_if.sv
`timescale 1ns/1ps

interface rd_port_if import cache_port_pkg::*; ();

    // request side driven by the arbiter
    logic    req;
    client_t client;
    addr_t   addr;

    // engine side
    // rdy high only while the engine is idle
    logic    rdy;
    // one-cycle completion pulse
    logic    ret_valid;
    // full line or the uncached word in word 0
    line_t   ret_data;

    modport arbiter (
        output req,
        output client,
        output addr,
        input  rdy,
        input  ret_valid,
        input  ret_data
    );

    modport engine (
        input  req,
        input  client,
        input  addr,
        output rdy,
        output ret_valid,
        output ret_data
    );

endinterface

//--- design/read_arbiter.sv
`timescale 1ns/1ps

module read_arbiter import cache_port_pkg::*; (
    input  logic      aclk,
    input  logic      reset,

    input  logic      icache_rd_req,
    input  addr_t     icache_rd_addr,
    output logic      icache_rd_rdy,
    output logic      icache_ret_valid,
    output line_t     icache_ret_data,

    input  logic      dcache_rd_req,
    input  addr_t     dcache_rd_addr,
    output logic      dcache_rd_rdy,
    output logic      dcache_ret_valid,
    output line_t     dcache_ret_data,

    input  logic      udcache_rd_req,
    input  addr_t     udcache_rd_addr,
    output logic      udcache_rd_rdy,
    output logic      udcache_ret_valid,
    output word_t     udcache_ret_data,

    rd_port_if.arbiter port
);

    client_t pick;
    addr_t   pick_addr;
    // client that owns the outstanding read
    client_t grant_q;

    // fixed priority with dcache over uncached over icache
    always_comb begin
        if (dcache_rd_req) begin
            pick      = CLIENT_DCACHE;
            pick_addr = dcache_rd_addr;
        end else if (udcache_rd_req) begin
            pick      = CLIENT_UNCACHED;
            pick_addr = udcache_rd_addr;
        end else begin
            pick      = CLIENT_ICACHE;
            pick_addr = icache_rd_addr;
        end
    end

    assign port.req    = icache_rd_req || dcache_rd_req || udcache_rd_req;
    assign port.client = pick;
    assign port.addr   = pick_addr;

    // a client sees rdy only when no higher priority client asks
    // with no request at all every rdy follows the engine
    assign dcache_rd_rdy  = port.rdy;
    assign udcache_rd_rdy = port.rdy && !dcache_rd_req;
    assign icache_rd_rdy  = port.rdy && !dcache_rd_req && !udcache_rd_req;

    // remember who was accepted
    always_ff @(posedge aclk) begin
        if (reset) begin
            grant_q <= CLIENT_ICACHE;
        end else if (port.req && port.rdy) begin
            grant_q <= pick;
        end
    end

    // steer the completion pulse back to the owner
    assign icache_ret_valid  = port.ret_valid && (grant_q == CLIENT_ICACHE);
    assign dcache_ret_valid  = port.ret_valid && (grant_q == CLIENT_DCACHE);
    assign udcache_ret_valid = port.ret_valid && (grant_q == CLIENT_UNCACHED);

    // data fans out and only the pulsed client samples it
    assign icache_ret_data  = port.ret_data;
    assign dcache_ret_data  = port.ret_data;
    // uncached word arrives in word 0
    assign udcache_ret_data = port.ret_data[$bits(word_t)-1:0];

endmodule

//--- files.f
design/axi_pkg.sv
design/cache_port_pkg.sv
design/rd_port_if.sv
design/read_arbiter.sv
design/axi_read_engine.sv
design/axi_write_engine.sv
design/axi_bridge_top.sv
sim/axi_slave_model.sv
sim/tb_axi_bridge.sv

//--- sim/axi_slave_model.sv
`timescale 1ns/1ps

module axi_slave_model import cache_port_pkg::*, axi_pkg::*; #(
    parameter integer SEED = 0
) (
    input  logic      aclk,
    input  logic      reset,
    // stall most cycles instead of a few
    input  logic      heavy,
    input  axi_id_t   arid,
    input  addr_t     araddr,
    input  axi_len_t  arlen,
    input  logic      arvalid,
    output logic      arready,
    output axi_id_t   rid,
    output word_t     rdata,
    output axi_resp_t rresp,
    output logic      rlast,
    output logic      rvalid,
    input  logic      rready,
    input  axi_id_t   awid,
    input  addr_t     awaddr,
    input  axi_len_t  awlen,
    input  logic      awvalid,
    output logic      awready,
    input  word_t     wdata,
    input  strb_t     wstrb,
    input  logic      wlast,
    input  logic      wvalid,
    output logic      wready,
    output axi_id_t   bid,
    output axi_resp_t bresp,
    output logic      bvalid,
    input  logic      bready
);

    integer     seed = SEED;
    // write region where bytes never written read back as fill
    logic [7:0] wmem [addr_t];

    // one burst per direction at a time
    logic       rd_busy;
    axi_id_t    r_id;
    addr_t      r_addr;
    axi_len_t   r_len;
    axi_len_t   r_cnt;
    logic       wr_busy;
    logic       b_pend;
    axi_id_t    w_id;
    addr_t      w_addr;
    axi_len_t   w_cnt;

    // read region content is the address mixed with a constant
    function automatic word_t read_word(input addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    // fill folds in every address byte
    function automatic logic [7:0] peek_byte(input addr_t a);
        if (wmem.exists(a)) begin
            return wmem[a];
        end
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];
    endfunction

    // willing to move this cycle
    function automatic logic go();
        if (heavy) begin
            return ($random(seed) & 3) == 0;
        end
        return ($random(seed) & 3) != 0;
    endfunction

    assign rid   = r_id;
    assign rdata = read_word(r_addr + {r_cnt, 2'b00});
    assign rresp = AXI_RESP_OKAY;
    assign rlast = (r_cnt == r_len);
    assign bid   = w_id;
    assign bresp = AXI_RESP_OKAY;

    always @(posedge aclk) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rd_busy <= 1'b0;
            r_id    <= '0;
            r_addr  <= '0;
            r_len   <= '0;
            r_cnt   <= '0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            wr_busy <= 1'b0;
            b_pend  <= 1'b0;
            w_id    <= '0;
            w_addr  <= '0;
            w_cnt   <= '0;
        end else begin
            // AR takes the address then closes until the burst ends
            if (arvalid && arready) begin
                r_id    <= arid;
                r_addr  <= araddr;
                r_len   <= arlen;
                r_cnt   <= '0;
                rd_busy <= 1'b1;
                arready <= 1'b0;
            end else begin
                arready <= !rd_busy && go();
            end
            // R beats hold valid until taken
            if (rvalid && rready) begin
                r_cnt <= r_cnt + 1'b1;
                if (rlast) begin
                    rvalid  <= 1'b0;
                    rd_busy <= 1'b0;
                end else begin
                    rvalid <= go();
                end
            end else if (rd_busy && !rvalid) begin
                rvalid <= go();
            end
            // AW
            if (awvalid && awready) begin
                w_id    <= awid;
                w_addr  <= awaddr;
                w_cnt   <= '0;
                wr_busy <= 1'b1;
                awready <= 1'b0;
            end else begin
                awready <= !wr_busy && go();
            end
            // W beats land in memory byte by byte
            if (wvalid && wready) begin
                for (int j = 0; j < 4; j++) begin
                    if (wstrb[j]) begin
                        wmem[addr_t'(w_addr + {w_cnt, 2'b00} + j)] = wdata[8*j +: 8];
                    end
                end
                w_cnt <= w_cnt + 1'b1;
                if (wlast) begin
                    wready <= 1'b0;
                    b_pend <= 1'b1;
                end else begin
                    wready <= go();
                end
            end else if (wr_busy && !b_pend) begin
                wready <= go();
            end
            // B after the last beat
            if (bvalid && bready) begin
                bvalid  <= 1'b0;
                b_pend  <= 1'b0;
                wr_busy <= 1'b0;
            end else if (b_pend && !bvalid) begin
                bvalid <= go();
            end
        end
    end

endmodule

//--- sim/tb_axi_bridge.sv
`timescale 1ns/1ps

module tb_axi_bridge import cache_port_pkg::*, axi_pkg::*; ();

    localparam integer SEED       = 32'h68abb94b;
    localparam int     WAIT_LIMIT = 4000;

    typedef enum int {RD_RDY, RD_DONE, WR_RDY, WR_DONE} wait_kind_t;

    logic      aclk;
    logic      reset;
    logic      heavy;
    // client side
    logic      icache_rd_req, icache_rd_rdy, icache_ret_valid;
    addr_t     icache_rd_addr;
    line_t     icache_ret_data;
    logic      dcache_rd_req, dcache_rd_rdy, dcache_ret_valid;
    addr_t     dcache_rd_addr;
    line_t     dcache_ret_data;
    logic      dcache_wr_req, dcache_wr_rdy, dcache_wr_valid;
    addr_t     dcache_wr_addr;
    line_t     dcache_wr_data;
    logic      udcache_rd_req, udcache_rd_rdy, udcache_ret_valid;
    addr_t     udcache_rd_addr;
    word_t     udcache_ret_data;
    logic      udcache_wr_req, udcache_wr_rdy, udcache_wr_valid;
    addr_t     udcache_wr_addr;
    strb_t     udcache_wr_strb;
    word_t     udcache_wr_data;
    // AXI side
    axi_id_t   arid, rid, awid, bid;
    addr_t     araddr, awaddr;
    axi_len_t  arlen, awlen;
    logic      arvalid, arready, rlast, rvalid, rready;
    logic      awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    word_t     rdata, wdata;
    strb_t     wstrb;
    axi_resp_t rresp, bresp;

    integer    seed = SEED;
    logic [7:0] ref_mem [addr_t];
    // last AR payload per id as seen at the handshake
    axi_len_t  seen_len [0:15];
    addr_t     seen_addr [0:15];
    // last AW length per id as seen at the handshake
    axi_len_t  seen_awlen [0:15];
    client_t   done_order [$];
    string     test_name;
    int        checks, errors, tests_run, tests_passed, errors_at;
    logic      timed_out = 1'b0;

    axi_bridge_top dut0 (.*);
    axi_slave_model #(.SEED(SEED)) slave0 (.*);

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    always @(negedge aclk) begin
        if (arvalid && arready) begin
            seen_len[arid]  = arlen;
            seen_addr[arid] = araddr;
        end
        if (awvalid && awready) begin
            seen_awlen[awid] = awlen;
        end
    end

    // a stuck wait ends the run here
    initial begin
        wait (timed_out === 1'b1);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // read region word is the address mixed with a constant
    function automatic word_t read_model(input addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    // write region reference with the same address fill as the slave memory
    function automatic word_t ref_word(input addr_t a);
        word_t w;
        addr_t b;
        for (int j = 0; j < 4; j++) begin
            b = a + j;
            w[8*j +: 8] = ref_mem.exists(b) ? ref_mem[b] : b[7:0] ^ b[15:8] ^ b[23:16] ^ b[31:24];
        end
        return w;
    endfunction

    function automatic word_t mem_word(input addr_t a);
        word_t w;
        for (int j = 0; j < 4; j++) begin
            w[8*j +: 8] = slave0.peek_byte(a + j);
        end
        return w;
    endfunction

    function automatic addr_t rand_addr(input addr_t base, input addr_t mask);
        return base | (addr_t'($random(seed)) & mask);
    endfunction

    function automatic line_t rand_line();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // bit index is the client code
    function automatic logic flag_of(input wait_kind_t k, input client_t c);
        logic [2:0] f;
        case (k)
            RD_RDY:  f = {udcache_rd_rdy, dcache_rd_rdy, icache_rd_rdy};
            RD_DONE: f = {udcache_ret_valid, dcache_ret_valid, icache_ret_valid};
            WR_RDY:  f = {udcache_wr_rdy, dcache_wr_rdy, 1'b0};
            default: f = {udcache_wr_valid, dcache_wr_valid, 1'b0};
        endcase
        return f[c];
    endfunction

    function automatic line_t ret_data_of(input client_t c);
        case (c)
            CLIENT_ICACHE: return icache_ret_data;
            CLIENT_DCACHE: return dcache_ret_data;
            default:       return line_t'(udcache_ret_data);
        endcase
    endfunction

    task automatic check_value(input string what, input line_t exp, input line_t got);
        checks++;
        assert (got === exp) else begin
            $display("error %s: %s expected %h actual %h", test_name, what, exp, got);
            errors++;
        end
    endtask

    // outputs sampled at the falling edge in mid cycle
    task automatic wait_flag(input wait_kind_t k, input client_t c, output bit ok);
        int cnt;
        cnt = 0;
        @(negedge aclk);
        while (!flag_of(k, c) && cnt < WAIT_LIMIT) begin
            @(negedge aclk);
            cnt++;
        end
        ok = flag_of(k, c);
        if (!ok) begin
            $display("timeout in %s: %s for %s never came", test_name, k.name(), c.name());
            timed_out = 1'b1;
        end
    endtask

    task automatic drive_rd(input client_t c, input logic v, input addr_t a);
        case (c)
            CLIENT_ICACHE: begin
                icache_rd_req  = v;
                icache_rd_addr = a;
            end
            CLIENT_DCACHE: begin
                dcache_rd_req  = v;
                dcache_rd_addr = a;
            end
            default: begin
                udcache_rd_req  = v;
                udcache_rd_addr = a;
            end
        endcase
    endtask

    task automatic drive_wr(input client_t c, input logic v, input addr_t a, input line_t d,
                            input strb_t s);
        if (c == CLIENT_DCACHE) begin
            dcache_wr_req  = v;
            dcache_wr_addr = a;
            dcache_wr_data = d;
        end else begin
            udcache_wr_req  = v;
            udcache_wr_addr = a;
            udcache_wr_strb = s;
            udcache_wr_data = d[31:0];
        end
    endtask

    task automatic read_req(input client_t c, input addr_t a);
        bit       ok;
        int       i;
        addr_t    base;
        line_t    exp;
        axi_len_t len;
        axi_id_t  id;
        exp = '0;
        // uncached keeps the word address while lines drop the offset
        if (c == CLIENT_UNCACHED) begin
            base       = a;
            len        = AXI_LEN_WORD;
            id         = ID_UNCACHED;
            exp[31:0]  = read_model(a);
        end else begin
            base = {a[31:4], 4'b0000};
            len  = AXI_LEN_LINE;
            id   = (c == CLIENT_DCACHE) ? ID_DCACHE : ID_ICACHE;
            for (i = 0; i < 4; i++) begin
                exp[32*i +: 32] = read_model(base + 4*i);
            end
        end
        @(posedge aclk);
        #1;
        drive_rd(c, 1'b1, a);
        wait_flag(RD_RDY, c, ok);
        if (!ok) return;
        @(posedge aclk);
        #1;
        drive_rd(c, 1'b0, '0);
        wait_flag(RD_DONE, c, ok);
        if (!ok) return;
        done_order.push_back(c);
        check_value({c.name(), " ret_data"}, exp, ret_data_of(c));
        check_value({c.name(), " arlen"}, line_t'(len), line_t'(seen_len[id]));
        check_value({c.name(), " araddr"}, line_t'(base), line_t'(seen_addr[id]));
    endtask

    task automatic write_req(input client_t c, input addr_t a, input line_t d, input strb_t s);
        bit       ok;
        int       i;
        int       nbytes;
        addr_t    base;
        axi_len_t len;
        axi_id_t  id;
        if (c == CLIENT_DCACHE) begin
            base   = {a[31:4], 4'b0000};
            nbytes = 16;
            len    = AXI_LEN_LINE;
            id     = ID_DCACHE;
        end else begin
            base   = a;
            nbytes = 4;
            len    = AXI_LEN_WORD;
            id     = ID_UNCACHED;
        end
        @(posedge aclk);
        #1;
        drive_wr(c, 1'b1, a, d, s);
        wait_flag(WR_RDY, c, ok);
        if (!ok) return;
        @(posedge aclk);
        #1;
        drive_wr(c, 1'b0, '0, '0, '0);
        // reference takes the bytes the slave should end up with
        for (i = 0; i < nbytes; i++) begin
            if (c == CLIENT_DCACHE) begin
                ref_mem[base + i] = d[8*i +: 8];
            end else if (s[i]) begin
                ref_mem[base + i] = d[8*i +: 8];
            end
        end
        wait_flag(WR_DONE, c, ok);
        if (!ok) return;
        check_value({c.name(), " awlen"}, line_t'(len), line_t'(seen_awlen[id]));
        for (i = 0; i < nbytes / 4; i++) begin
            check_value({c.name(), " memory word"}, line_t'(ref_word(base + 4*i)),
                        line_t'(mem_word(base + 4*i)));
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errors_at = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errors_at) begin
            tests_passed++;
            $display("test %-16s pass", test_name);
        end else begin
            $display("test %-16s fail, %0d errors", test_name, errors - errors_at);
        end
    endtask

    initial begin
        addr_t   a_i, a_d, a_u, a_w, a_x;
        line_t   d_w, d_x;
        client_t c;
        reset = 1'b1;
        heavy = 1'b0;
        drive_rd(CLIENT_ICACHE, 1'b0, '0);
        drive_rd(CLIENT_DCACHE, 1'b0, '0);
        drive_rd(CLIENT_UNCACHED, 1'b0, '0);
        drive_wr(CLIENT_DCACHE, 1'b0, '0, '0, '0);
        drive_wr(CLIENT_UNCACHED, 1'b0, '0, '0, '0);
        repeat (3) @(posedge aclk);
        #1;
        reset = 1'b0;

        // AXI valids low, completions low, every rdy high
        begin_test("reset_state");
        @(negedge aclk);
        check_value("idle outputs", line_t'(15'b000000000011111),
                    line_t'({arvalid, awvalid, wvalid, bready, rready, icache_ret_valid,
                             dcache_ret_valid, udcache_ret_valid, dcache_wr_valid,
                             udcache_wr_valid, icache_rd_rdy, dcache_rd_rdy,
                             udcache_rd_rdy, dcache_wr_rdy, udcache_wr_rdy}));
        end_test();

        begin_test("line_reads");
        repeat (12) begin
            c = ($random(seed) & 1) ? CLIENT_DCACHE : CLIENT_ICACHE;
            read_req(c, rand_addr(32'h1000_0000, 32'h000f_ffff));
        end
        end_test();

        begin_test("uncached_reads");
        repeat (12) begin
            read_req(CLIENT_UNCACHED, rand_addr(32'h1000_0000, 32'h000f_fffc));
        end
        end_test();

        // all three raised in one cycle
        begin_test("read_priority");
        repeat (3) begin
            done_order.delete();
            a_i = rand_addr(32'h1000_0000, 32'h000f_ffff);
            a_d = rand_addr(32'h1000_0000, 32'h000f_ffff);
            a_u = rand_addr(32'h1000_0000, 32'h000f_fffc);
            fork
                read_req(CLIENT_DCACHE, a_d);
                read_req(CLIENT_UNCACHED, a_u);
                read_req(CLIENT_ICACHE, a_i);
            join
            check_value("completions", 3, done_order.size());
            if (done_order.size() == 3) begin
                check_value("completion order",
                            line_t'({CLIENT_DCACHE, CLIENT_UNCACHED, CLIENT_ICACHE}),
                            line_t'({done_order[0], done_order[1], done_order[2]}));
            end
        end
        end_test();

        begin_test("line_writes");
        repeat (10) begin
            write_req(CLIENT_DCACHE, rand_addr(32'h8000_0000, 32'h0000_0fff), rand_line(), '1);
        end
        end_test();

        // small window so strobed words get hit more than once
        begin_test("uncached_writes");
        repeat (16) begin
            a_x = rand_addr(32'h8000_1000, 32'h0000_00fc);
            write_req(CLIENT_UNCACHED, a_x, rand_line(), strb_t'($random(seed)));
        end
        end_test();

        begin_test("stalled_mix");
        @(posedge aclk);
        #1;
        heavy = 1'b1;
        repeat (6) begin
            a_i = rand_addr(32'h1000_0000, 32'h000f_ffff);
            a_d = rand_addr(32'h1000_0000, 32'h000f_ffff);
            a_u = rand_addr(32'h1000_0000, 32'h000f_fffc);
            a_w = rand_addr(32'h8000_0000, 32'h0000_0fff);
            a_x = rand_addr(32'h8000_1000, 32'h0000_00fc);
            d_w = rand_line();
            d_x = rand_line();
            fork
                read_req(CLIENT_ICACHE, a_i);
                read_req(CLIENT_DCACHE, a_d);
                read_req(CLIENT_UNCACHED, a_u);
                write_req(CLIENT_DCACHE, a_w, d_w, '1);
                write_req(CLIENT_UNCACHED, a_x, d_x, strb_t'($random(seed)));
            join
        end
        heavy = 1'b0;
        end_test();

        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
